// File: Makefile
TOP     = tb_ising_energy_core
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) \
		-Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// File: files.f
hdl/ising_pkg.sv
hdl/block_sequencer.sv
hdl/coupling_field.sv
hdl/bias_field.sv
hdl/energy_accumulator.sv
hdl/best_energy_keeper.sv
hdl/ising_energy_core.sv
verification/energy_checker.sv
verification/ising_energy_core_asserts.sv
verification/tb_ising_energy_core.sv

// File: hdl/best_energy_keeper.sv
/* best energy keeper: lowest energy and its spin vector */
module best_energy_keeper
    import ising_pkg::*;
#(
    parameter int NUM_SPIN = ising_pkg::NUM_SPIN
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  energy_t             energy_i,
    input  logic                energy_valid_i,
    input  logic [NUM_SPIN-1:0] spin_i,
    output energy_t             best_energy_o,
    output logic [NUM_SPIN-1:0] best_spin_o,
    output logic                best_update_o
);

    logic has_best_q;

    // strictly lower, or nothing stored yet
    assign best_update_o = energy_valid_i & (~has_best_q | (energy_i < best_energy_o));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            has_best_q <= 1'b0;
        end else if (flush_i) begin
            has_best_q <= 1'b0;
        end else if (best_update_o) begin
            has_best_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (best_update_o) begin
            best_energy_o <= energy_i;
            best_spin_o   <= spin_i;
        end
    end

endmodule

// File: hdl/bias_field.sv
/* bias field: scaled h for the rows of the current block */
module bias_field
    import ising_pkg::*;
#(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [J_ADDR_BIT-1:0]    blk_idx_i,
    input  logic [NUM_SPIN*BITH-1:0] h_bias_i,
    input  logic [SCALING_BIT-1:0]   h_scaling_i,
    output field_t [PARALLELISM-1:0] bias_o
);

    field_t [PARALLELISM-1:0] bias_d;

    always_comb begin
        for (int r = 0; r < PARALLELISM; r++) begin
            // signed h times unsigned scaling
            bias_d[r] = field_t'(signed'(h_bias_i[(blk_idx_i*PARALLELISM + r)*BITH +: BITH]))
                      * field_t'(h_scaling_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bias_o <= '0;
        end else begin
            bias_o <= bias_d;
        end
    end

endmodule

// File: hdl/block_sequencer.sv
/* block sequencer: spin handshake, J memory reads
   and block info aligned with the returned data */
module block_sequencer
    import ising_pkg::*;
#(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 spin_valid_i,
    input  logic [NUM_SPIN-1:0]                  spin_i,
    output logic                                 spin_ready_o,
    output logic                                 j_ren_o,
    output logic [J_ADDR_BIT-1:0]                j_raddr_o,
    input  logic [NUM_SPIN*BITJ*PARALLELISM-1:0] j_rdata_i,
    output logic                                 blk_valid_o,
    output logic                                 blk_last_o,
    output logic [J_ADDR_BIT-1:0]                blk_idx_o,
    output logic [NUM_SPIN*BITJ*PARALLELISM-1:0] blk_weight_o,
    output logic [NUM_SPIN-1:0]                  blk_spin_o
);

    localparam int BLOCKS = NUM_SPIN / PARALLELISM;

    logic                busy_q;
    logic                rd_last;
    logic                last_d2_q;
    logic [NUM_SPIN-1:0] spin_q;
    logic                accept;

    assign spin_ready_o = ~busy_q;
    assign accept       = spin_valid_i & spin_ready_o;
    assign rd_last      = (j_raddr_o == J_ADDR_BIT'(BLOCKS - 1));

    // read strobe and address counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            j_ren_o   <= 1'b0;
            j_raddr_o <= '0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            j_ren_o   <= 1'b1;
            j_raddr_o <= '0;
        end else begin
            if (j_ren_o) begin
                if (rd_last) begin
                    j_ren_o <= 1'b0;
                end else begin
                    j_raddr_o <= j_raddr_o + 1'b1;
                end
            end
            // last block reaches the field stage, idle again next cycle
            if (last_d2_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    // one cycle delay to meet the memory read latency
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            blk_valid_o <= 1'b0;
            blk_last_o  <= 1'b0;
            blk_idx_o   <= '0;
            last_d2_q   <= 1'b0;
        end else begin
            blk_valid_o <= j_ren_o;
            blk_last_o  <= j_ren_o & rd_last;
            blk_idx_o   <= j_raddr_o;
            last_d2_q   <= blk_last_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            spin_q <= spin_i;
        end
    end

    assign blk_weight_o = j_rdata_i;
    assign blk_spin_o   = spin_q;

endmodule

// File: hdl/coupling_field.sv
/* coupling field: signed J-by-sigma dot product
   for each row of a block, registered */
module coupling_field
    import ising_pkg::*;
#(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 blk_valid_i,
    input  logic                                 blk_last_i,
    input  logic [J_ADDR_BIT-1:0]                blk_idx_i,
    input  logic [NUM_SPIN*BITJ*PARALLELISM-1:0] blk_weight_i,
    input  logic [NUM_SPIN-1:0]                  blk_spin_i,
    output logic                                 row_valid_o,
    output logic                                 row_last_o,
    output logic [PARALLELISM-1:0]               row_sigma_o,
    output field_t [PARALLELISM-1:0]             row_field_o
);

    field_t [PARALLELISM-1:0] row_sum;

    always_comb begin
        field_t j_ext;
        for (int r = 0; r < PARALLELISM; r++) begin
            row_sum[r] = '0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                j_ext = field_t'(signed'(blk_weight_i[(r*NUM_SPIN + j)*BITJ +: BITJ]));
                // sigma +1 adds, sigma -1 subtracts
                if (blk_spin_i[j]) begin
                    row_sum[r] = row_sum[r] + j_ext;
                end else begin
                    row_sum[r] = row_sum[r] - j_ext;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            row_valid_o <= 1'b0;
            row_last_o  <= 1'b0;
        end else begin
            row_valid_o <= blk_valid_i;
            row_last_o  <= blk_valid_i & blk_last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (blk_valid_i) begin
            row_field_o <= row_sum;
            row_sigma_o <= blk_spin_i[blk_idx_i*PARALLELISM +: PARALLELISM];
        end
    end

endmodule

// File: hdl/energy_accumulator.sv
/* energy accumulator: sigma-weighted block sums,
   running total and end-of-vector energy pulse */
module energy_accumulator
    import ising_pkg::*;
#(
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     row_valid_i,
    input  logic                     row_last_i,
    input  logic [PARALLELISM-1:0]   row_sigma_i,
    input  field_t [PARALLELISM-1:0] row_field_i,
    input  field_t [PARALLELISM-1:0] bias_i,
    output energy_t                  energy_o,
    output logic                     energy_valid_o
);

    energy_t total_q;
    energy_t blk_sum;

    always_comb begin
        energy_t local_field;
        blk_sum = '0;
        for (int r = 0; r < PARALLELISM; r++) begin
            local_field = energy_t'(row_field_i[r]) + energy_t'(bias_i[r]);
            blk_sum = row_sigma_i[r] ? blk_sum + local_field : blk_sum - local_field;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            total_q        <= '0;
            energy_valid_o <= 1'b0;
        end else begin
            energy_valid_o <= row_valid_i & row_last_i;
            if (row_valid_i) begin
                // restart at zero after the last block
                total_q <= row_last_i ? '0 : total_q + blk_sum;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (row_valid_i && row_last_i) begin
            energy_o <= total_q + blk_sum;
        end
    end

endmodule

// File: hdl/ising_energy_core.sv
/* ising energy core top level: sequencer, field stages,
   accumulator and best energy keeper */
module ising_energy_core
    import ising_pkg::*;
#(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  logic                                 spin_valid_i,
    input  logic [NUM_SPIN-1:0]                  spin_i,
    output logic                                 spin_ready_o,
    output logic                                 j_ren_o,
    output logic [J_ADDR_BIT-1:0]                j_raddr_o,
    input  logic [NUM_SPIN*BITJ*PARALLELISM-1:0] j_rdata_i,
    input  logic [NUM_SPIN*BITH-1:0]             h_bias_i,
    input  logic [SCALING_BIT-1:0]               h_scaling_i,
    output energy_t                              energy_o,
    output logic                                 energy_valid_o,
    output energy_t                              best_energy_o,
    output logic [NUM_SPIN-1:0]                  best_spin_o,
    output logic                                 best_update_o
);

    logic                                 blk_valid;
    logic                                 blk_last;
    logic [J_ADDR_BIT-1:0]                blk_idx;
    logic [NUM_SPIN*BITJ*PARALLELISM-1:0] blk_weight;
    logic [NUM_SPIN-1:0]                  blk_spin;
    logic                                 row_valid;
    logic                                 row_last;
    logic [PARALLELISM-1:0]               row_sigma;
    field_t [PARALLELISM-1:0]             row_field;
    field_t [PARALLELISM-1:0]             bias;

    block_sequencer #(
        .NUM_SPIN     (NUM_SPIN),
        .PARALLELISM  (PARALLELISM)
    ) u_block_sequencer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .spin_valid_i (spin_valid_i),
        .spin_i       (spin_i),
        .spin_ready_o (spin_ready_o),
        .j_ren_o      (j_ren_o),
        .j_raddr_o    (j_raddr_o),
        .j_rdata_i    (j_rdata_i),
        .blk_valid_o  (blk_valid),
        .blk_last_o   (blk_last),
        .blk_idx_o    (blk_idx),
        .blk_weight_o (blk_weight),
        .blk_spin_o   (blk_spin)
    );

    coupling_field #(
        .NUM_SPIN     (NUM_SPIN),
        .PARALLELISM  (PARALLELISM)
    ) u_coupling_field (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .blk_valid_i  (blk_valid),
        .blk_last_i   (blk_last),
        .blk_idx_i    (blk_idx),
        .blk_weight_i (blk_weight),
        .blk_spin_i   (blk_spin),
        .row_valid_o  (row_valid),
        .row_last_o   (row_last),
        .row_sigma_o  (row_sigma),
        .row_field_o  (row_field)
    );

    bias_field #(
        .NUM_SPIN     (NUM_SPIN),
        .PARALLELISM  (PARALLELISM)
    ) u_bias_field (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .blk_idx_i    (blk_idx),
        .h_bias_i     (h_bias_i),
        .h_scaling_i  (h_scaling_i),
        .bias_o       (bias)
    );

    energy_accumulator #(
        .PARALLELISM    (PARALLELISM)
    ) u_energy_accumulator (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .row_valid_i    (row_valid),
        .row_last_i     (row_last),
        .row_sigma_i    (row_sigma),
        .row_field_i    (row_field),
        .bias_i         (bias),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o)
    );

    // held spin vector is still stable at the energy pulse
    best_energy_keeper #(
        .NUM_SPIN       (NUM_SPIN)
    ) u_best_energy_keeper (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .energy_i       (energy_o),
        .energy_valid_i (energy_valid_o),
        .spin_i         (blk_spin),
        .best_energy_o  (best_energy_o),
        .best_spin_o    (best_spin_o),
        .best_update_o  (best_update_o)
    );

endmodule

// File: hdl/ising_pkg.sv
/* widths, derived constants and element types
   shared by the ising energy core */
package ising_pkg;

    localparam int NUM_SPIN         = 16;
    localparam int BITJ             = 4;
    localparam int BITH             = BITJ;
    localparam int SCALING_BIT      = 4;
    localparam int PARALLELISM      = 4;
    localparam int ENERGY_TOTAL_BIT = 32;

    // J memory holds PARALLELISM rows per word
    localparam int NUM_BLOCKS       = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_BIT       = $clog2(NUM_BLOCKS);

    // row fields carry the full energy width
    localparam int FIELD_BIT        = ENERGY_TOTAL_BIT;

    typedef logic signed [FIELD_BIT-1:0]        field_t;
    typedef logic signed [ENERGY_TOTAL_BIT-1:0] energy_t;

endpackage

// File: verification/energy_checker.sv
/* reference energy model, expected best tracking and
   comparison of the core's energy and best outputs */
module energy_checker
    import ising_pkg::*;
#(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic                              spin_valid_i,
    input  logic                              spin_ready_i,
    input  logic [NUM_SPIN-1:0]               spin_i,
    input  logic [NUM_SPIN*NUM_SPIN*BITJ-1:0] j_all_i,
    input  logic [NUM_SPIN*BITH-1:0]          h_bias_i,
    input  logic [SCALING_BIT-1:0]            h_scaling_i,
    input  energy_t                           energy_i,
    input  logic                              energy_valid_i,
    input  energy_t                           best_energy_i,
    input  logic [NUM_SPIN-1:0]               best_spin_i,
    input  logic                              best_update_i,
    output int                                err_count_o,
    output int                                energy_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY = NUM_SPIN / PARALLELISM + 3;

    int                  exp_energy_q[$];
    logic [NUM_SPIN-1:0] exp_spin_q[$];
    int                  start_q[$];
    int                  cycle = 0;
    int                  errors = 0;
    int                  energies = 0;
    logic                has_best = 1'b0;
    int                  best_energy;
    logic [NUM_SPIN-1:0] best_spin;

    assign err_count_o    = errors;
    assign energy_count_o = energies;

    // sum over i of sigma(i) * (sum over j of J(i,j)*sigma(j) + hscaling*h(i))
    function automatic int reference_energy(input logic [NUM_SPIN-1:0] s);
        int total;
        int field;
        total = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            field = int'(h_scaling_i) * int'($signed(h_bias_i[i*BITH +: BITH]));
            for (int j = 0; j < NUM_SPIN; j++) begin
                field += (s[j] ? 1 : -1) * int'($signed(j_all_i[(i*NUM_SPIN + j)*BITJ +: BITJ]));
            end
            total += s[i] ? field : -field;
        end
        return total;
    endfunction

    // sampled mid-cycle, away from the clock edge
    always @(negedge clk_i) begin
        int                  exp_e;
        logic [NUM_SPIN-1:0] exp_s;
        int                  start;
        logic                exp_upd;
        cycle   = cycle + 1;
        exp_upd = 1'b0;
        if (rst_n_i) begin
            if (has_best && best_energy_i !== best_energy) begin
                $display("MISMATCH best_energy_o got %h expected %h", best_energy_i, best_energy);
                errors++;
            end
            if (has_best && best_spin_i !== best_spin) begin
                $display("MISMATCH best_spin_o got %h expected %h", best_spin_i, best_spin);
                errors++;
            end
            if (energy_valid_i && exp_energy_q.size() == 0) begin
                $display("energy_valid_o pulsed with no spin vector in flight");
                errors++;
            end else if (energy_valid_i) begin
                exp_e = exp_energy_q.pop_front();
                exp_s = exp_spin_q.pop_front();
                start = start_q.pop_front();
                energies++;
                if (cycle - start != LATENCY) begin
                    $display("energy_valid_o came %0d cycles after the handshake, not %0d",
                             cycle - start, LATENCY);
                    errors++;
                end
                if (energy_i !== exp_e) begin
                    $display("MISMATCH energy_o got %h expected %h", energy_i, exp_e);
                    errors++;
                end
                exp_upd = !has_best || (exp_e < best_energy);
                if (exp_upd) begin
                    best_energy = exp_e;
                    best_spin   = exp_s;
                    has_best    = 1'b1;
                end
            end
            if (best_update_i !== exp_upd) begin
                $display("MISMATCH best_update_o got %h expected %h", best_update_i, exp_upd);
                errors++;
            end
            if (flush_i) begin
                has_best = 1'b0;
            end
            if (spin_valid_i && spin_ready_i) begin
                exp_energy_q.push_back(reference_energy(spin_i));
                exp_spin_q.push_back(spin_i);
                start_q.push_back(cycle);
            end
        end
    end

endmodule

// File: verification/ising_energy_core_asserts.sv
/* concurrent assertions on the J read sequence, reset state
   and energy pulse of the core, bound to the top level */
module ising_energy_core_asserts
    import ising_pkg::*;
#(
    parameter int BLOCKS = ising_pkg::NUM_BLOCKS
) (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  spin_ready_o,
    input logic                  j_ren_o,
    input logic [J_ADDR_BIT-1:0] j_raddr_o,
    input logic                  energy_valid_o,
    input logic                  best_update_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [J_ADDR_BIT-1:0] LAST_ADDR = J_ADDR_BIT'(BLOCKS - 1);

    reset_state: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> spin_ready_o && !j_ren_o && !energy_valid_o && !best_update_o)
        else $error("core not idle when reset is released");

    ren_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        j_ren_o |-> !spin_ready_o)
        else $error("j_ren_o high while spin_ready_o is high");

    first_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(j_ren_o) |-> j_raddr_o == '0)
        else $error("read burst does not start at address zero");

    // addresses step by one until the last block
    addr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        j_ren_o && j_raddr_o != LAST_ADDR |=>
            j_ren_o && j_raddr_o == J_ADDR_BIT'($past(j_raddr_o) + 1'b1))
        else $error("read burst broken or address out of order");

    read_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        j_ren_o && j_raddr_o == LAST_ADDR |=> !j_ren_o)
        else $error("j_ren_o still high after the last block address");

    valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        energy_valid_o |=> !energy_valid_o)
        else $error("energy_valid_o high for two cycles in a row");

endmodule

bind ising_energy_core ising_energy_core_asserts #(
    .BLOCKS         (NUM_SPIN / PARALLELISM)
) u_asserts (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .spin_ready_o   (spin_ready_o),
    .j_ren_o        (j_ren_o),
    .j_raddr_o      (j_raddr_o),
    .energy_valid_o (energy_valid_o),
    .best_update_o  (best_update_o)
);

// File: verification/tb_ising_energy_core.sv
/* testbench for the ising energy core: clock, reset, J memory model,
   stimulus table loop, timeout and closing report */
module tb_ising_energy_core
    import ising_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ENTRIES    = 10;
    localparam int WORD_BIT       = NUM_SPIN * BITJ * PARALLELISM;
    localparam int TIMEOUT_CYCLES = 8 + NUM_ENTRIES * (NUM_BLOCKS + 5) + 20;
    // entries that flush the best value first
    localparam logic [NUM_ENTRIES-1:0] FLUSH_AT = 10'b00_1001_0000;

    logic                              clk_i;
    logic                              rst_n_i;
    logic                              flush_i;
    logic                              spin_valid_i;
    logic                              spin_ready_o;
    logic                              j_ren_o;
    logic                              energy_valid_o;
    logic                              best_update_o;
    logic [NUM_SPIN-1:0]               spin_i;
    logic [NUM_SPIN-1:0]               best_spin_o;
    logic [J_ADDR_BIT-1:0]             j_raddr_o;
    logic [WORD_BIT-1:0]               j_rdata_i;
    logic [NUM_SPIN*BITH-1:0]          h_bias_i;
    logic [SCALING_BIT-1:0]            h_scaling_i;
    energy_t                           energy_o;
    energy_t                           best_energy_o;
    logic [NUM_SPIN*NUM_SPIN*BITJ-1:0] j_all;
    logic [NUM_SPIN-1:0]               tab_spin [NUM_ENTRIES];
    logic [31:0]                       rng;
    int                                cycles = 0;
    int                                err_count;
    int                                energy_count;

    ising_energy_core #(
        .NUM_SPIN       (NUM_SPIN),
        .PARALLELISM    (PARALLELISM)
    ) i_ising_energy_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .spin_valid_i   (spin_valid_i),
        .spin_i         (spin_i),
        .spin_ready_o   (spin_ready_o),
        .j_ren_o        (j_ren_o),
        .j_raddr_o      (j_raddr_o),
        .j_rdata_i      (j_rdata_i),
        .h_bias_i       (h_bias_i),
        .h_scaling_i    (h_scaling_i),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o),
        .best_energy_o  (best_energy_o),
        .best_spin_o    (best_spin_o),
        .best_update_o  (best_update_o)
    );

    energy_checker #(
        .NUM_SPIN       (NUM_SPIN),
        .PARALLELISM    (PARALLELISM)
    ) u_energy_checker (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .spin_valid_i   (spin_valid_i),
        .spin_ready_i   (spin_ready_o),
        .spin_i         (spin_i),
        .j_all_i        (j_all),
        .h_bias_i       (h_bias_i),
        .h_scaling_i    (h_scaling_i),
        .energy_i       (energy_o),
        .energy_valid_i (energy_valid_o),
        .best_energy_i  (best_energy_o),
        .best_spin_i    (best_spin_o),
        .best_update_i  (best_update_o),
        .err_count_o    (err_count),
        .energy_count_o (energy_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_weights_and_table();
        for (int k = 0; k < NUM_SPIN * NUM_SPIN; k++) begin
            rng = xorshift(rng);
            j_all[k*BITJ +: BITJ] = rng[31 -: BITJ];
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            rng = xorshift(rng);
            h_bias_i[i*BITH +: BITH] = rng[31 -: BITH];
        end
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            rng = xorshift(rng);
            tab_spin[k] = NUM_SPIN'(rng);
        end
        tab_spin[0] = '1;
        tab_spin[1] = '0;
        // all ones again right after the first flush
        tab_spin[4] = '1;
        // equal energy after the second flush keeps the best
        tab_spin[8] = tab_spin[7];
    endtask

    task automatic wait_idle();
        while (!spin_ready_o) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic apply_entry(input int k);
        if (FLUSH_AT[k]) begin
            wait_idle();
            // one cycle past the previous energy pulse
            @(posedge clk_i);
            #1 flush_i = 1'b1;
            @(posedge clk_i);
            #1 flush_i = 1'b0;
        end
        spin_valid_i = 1'b1;
        spin_i       = tab_spin[k];
        wait_idle();
        @(posedge clk_i);
        #1 spin_valid_i = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // J memory with one cycle read latency
    always @(posedge clk_i) begin
        logic                  ren;
        logic [J_ADDR_BIT-1:0] addr;
        ren  = j_ren_o;
        addr = j_raddr_o;
        #1;
        if (ren) begin
            j_rdata_i = j_all[addr*WORD_BIT +: WORD_BIT];
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d energies seen",
                     cycles, energy_count, NUM_ENTRIES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rng          = 32'hca8822c9;
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        spin_valid_i = 1'b0;
        spin_i       = '0;
        j_rdata_i    = '0;
        h_bias_i     = '0;
        h_scaling_i  = 4'd3;
        fill_weights_and_table();
        repeat (8) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            apply_entry(k);
        end
        while (energy_count < NUM_ENTRIES) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        $display("errors: %0d, energies checked: %0d of %0d", err_count, energy_count,
                 NUM_ENTRIES);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
